//--- bench/decompress_tb_tasks.svh
// Testbench checks and directed tests
`ifndef DECOMPRESS_TB_TASKS_SVH
`define DECOMPRESS_TB_TASKS_SVH

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("FAILED: %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic int unsigned width_of_mode(
        input decompress_defines_pkg::decompress_mode_t mode
    );
        case (mode)
            decompress_defines_pkg::decompress1:  return 1;
            decompress_defines_pkg::decompress5:  return 5;
            decompress_defines_pkg::decompress11: return 11;
            default:                              return 12;
        endcase
    endfunction

    function automatic int unsigned job_cycle_budget(input int unsigned d,
                                                     input int unsigned num_poly);
        return (num_poly * d * 4 + num_poly * 64 + 20) * 4;
    endfunction

    // Field k of the stream sits at bit k*d, rounded scaling to q
    function automatic int unsigned expected_coeff(input int unsigned src, input int unsigned d,
                                                   input int unsigned k);
        int unsigned value;
        int unsigned bit_pos;
        value = 0;
        for (int b = 0; b < d; b++) begin
            bit_pos = k * d + b;
            value |= 32'(src_mem[src + bit_pos / 64][bit_pos % 64]) << b;
        end
        return (value * abr_params_pkg::MLKEM_Q + (1 << (d - 1))) >> d;
    endfunction

    function automatic logic [95:0] expected_lanes(input int unsigned src, input int unsigned d,
                                                   input int unsigned w);
        logic [95:0] lanes;
        lanes = '0;
        for (int i = 0; i < 4; i++) begin
            lanes[i*24 +: 24] = 24'(expected_coeff(src, d, w * 4 + i));
        end
        return lanes;
    endfunction

    task automatic clear_records();
        rd_addr_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        done_count = 0;
    endtask

    task automatic start_job(input decompress_defines_pkg::decompress_mode_t mode,
                             input int unsigned num_poly, input int unsigned src,
                             input int unsigned dest);
        @(negedge clk);
        clear_records();
        mode_i = mode;
        num_poly_i = 3'(num_poly);
        src_base_addr_i = abr_params_pkg::mem_addr_t'(src);
        dest_base_addr_i = abr_params_pkg::mem_addr_t'(dest);
        decompress_enable_i = 1'b1;
        @(negedge clk);
        decompress_enable_i = 1'b0;
    endtask

    task automatic run_job(input decompress_defines_pkg::decompress_mode_t mode,
                           input int unsigned num_poly, input int unsigned src,
                           input int unsigned dest);
        int unsigned d;
        d = width_of_mode(mode);
        start_job(mode, num_poly, src, dest);
        while (done_count == 0) @(negedge clk);
        // Quiet window where a late read, write or second done would show
        repeat (10) @(negedge clk);
        check_value("decompress_done_o pulses", done_count, 1);
        check_value("decompress_done_o cycle", done_cycle, last_wr_cycle + 1);
        check_value("api_rd_en_o count", rd_addr_q.size(), num_poly * d * 4);
        check_value("mem_wr_req_o count", wr_addr_q.size(), num_poly * 64);
        if (last_rd_cycle >= done_cycle) begin
            abort_run("a read was issued after the done pulse");
        end
        for (int r = 0; r < rd_addr_q.size(); r++) begin
            check_value("api_rd_addr_o", rd_addr_q[r], abr_params_pkg::mem_addr_t'(src + r));
        end
        for (int w = 0; w < wr_addr_q.size(); w++) begin
            check_value("mem_wr_req_o.addr", wr_addr_q[w], abr_params_pkg::mem_addr_t'(dest + w));
            check_value("mem_wr_data_o", wr_data_q[w], expected_lanes(src, d, w));
        end
    endtask

    task automatic test_mode1_single();
        run_job(decompress_defines_pkg::decompress1, 1, 'h010, 'h1000);
    endtask

    // Narrow and wide rates both stall reads on a full buffer
    task automatic test_throttled_modes();
        run_job(decompress_defines_pkg::decompress5, 2, 'h020, 'h2000);
        run_job(decompress_defines_pkg::decompress11, 2, 'h050, 'h3000);
    endtask

    task automatic test_mode12_boundaries();
        logic [95:0] first;
        // Coefficient 0 is all zeros, coefficient 1 all ones
        src_mem['h100][23:0] = 24'hfff000;
        run_job(decompress_defines_pkg::decompress12, 4, 'h100, 'h4000);
        first = wr_data_q[0];
        check_value("lane 0 for input 0", first[23:0], 0);
        check_value("lane 1 for input 4095", first[47:24], 3328);
    endtask

    task automatic test_zeroize_abort();
        start_job(decompress_defines_pkg::decompress11, 2, 'h040, 'h5000);
        while (wr_addr_q.size() < 16) @(negedge clk);
        zeroize_i = 1'b1;
        repeat (2) @(negedge clk);
        zeroize_i = 1'b0;
        clear_records();
        repeat (40) @(negedge clk);
        check_value("writes after zeroize", wr_addr_q.size(), 0);
        check_value("reads after zeroize", rd_addr_q.size(), 0);
        check_value("done after zeroize", done_count, 0);
        run_job(decompress_defines_pkg::decompress5, 1, 'h0b0, 'h6000);
    endtask

`endif

//--- bench/decompress_top_tb.sv
// Decompression engine testbench
`default_nettype none

module decompress_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SRC_DEPTH = 512;

    logic clk = 1'b0;
    logic reset_n;
    logic zeroize_i;
    logic decompress_enable_i;
    decompress_defines_pkg::decompress_mode_t mode_i;
    logic [2:0] num_poly_i;
    abr_params_pkg::mem_addr_t src_base_addr_i;
    abr_params_pkg::mem_addr_t dest_base_addr_i;
    abr_params_pkg::mem_if_t mem_wr_req_o;
    logic [abr_params_pkg::COEFF_PER_CLK-1:0][abr_params_pkg::MLDSA_Q_WIDTH-1:0] mem_wr_data_o;
    logic api_rd_en_o;
    abr_params_pkg::mem_addr_t api_rd_addr_o;
    logic [1:0][abr_params_pkg::DATA_WIDTH-1:0] api_rd_data_i;
    logic decompress_done_o;

    // Source memory, one 64-bit chunk per address
    logic [63:0] src_mem [SRC_DEPTH];
    logic rd_pending;
    abr_params_pkg::mem_addr_t rd_pending_addr;

    // What the DUT did during the current job
    abr_params_pkg::mem_addr_t rd_addr_q[$];
    abr_params_pkg::mem_addr_t wr_addr_q[$];
    logic [95:0] wr_data_q[$];
    int unsigned done_count = 0;
    int unsigned cycle_cnt = 0;
    int unsigned last_rd_cycle = 0;
    int unsigned last_wr_cycle = 0;
    int unsigned done_cycle = 0;
    int unsigned fail_count = 0;

    decompress_top decompress_top_inst (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .decompress_enable_i(decompress_enable_i),
        .mode_i(mode_i),
        .num_poly_i(num_poly_i),
        .src_base_addr_i(src_base_addr_i),
        .dest_base_addr_i(dest_base_addr_i),
        .mem_wr_req_o(mem_wr_req_o),
        .mem_wr_data_o(mem_wr_data_o),
        .api_rd_en_o(api_rd_en_o),
        .api_rd_addr_o(api_rd_addr_o),
        .api_rd_data_i(api_rd_data_i),
        .decompress_done_o(decompress_done_o)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    `include "decompress_tb_tasks.svh"

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Read port, data follows one cycle after the request
    always @(posedge clk) begin
        rd_pending <= api_rd_en_o;
        rd_pending_addr <= api_rd_addr_o;
        if (api_rd_en_o === 1'b1) begin
            rd_addr_q.push_back(api_rd_addr_o);
            last_rd_cycle = cycle_cnt;
        end
    end

    always @(negedge clk) begin
        if (rd_pending === 1'b1) begin
            if (rd_pending_addr >= SRC_DEPTH) begin
                abort_run("read address lies outside the source memory model");
            end else begin
                api_rd_data_i = src_mem[rd_pending_addr];
            end
        end
    end

    // Write and done monitor
    always @(posedge clk) begin
        if (mem_wr_req_o.rd_wr_en === abr_params_pkg::RW_WRITE) begin
            wr_addr_q.push_back(mem_wr_req_o.addr);
            wr_data_q.push_back(mem_wr_data_o);
            last_wr_cycle = cycle_cnt;
        end
        if (decompress_done_o === 1'b1) begin
            done_count++;
            done_cycle = cycle_cnt;
        end
    end

    initial begin : watchdog
        int unsigned limit;
        limit = job_cycle_budget(1, 1) + job_cycle_budget(5, 2) + job_cycle_budget(11, 2)
              + job_cycle_budget(12, 4) + job_cycle_budget(11, 2) + job_cycle_budget(5, 1);
        repeat (limit) @(posedge clk);
        abort_run($sformatf("Timeout: tests did not finish within %0d cycles", limit));
    end

    initial begin
        void'($urandom(32'hcd8c_9c9b));
        reset_n = 1'b0;
        zeroize_i = 1'b0;
        decompress_enable_i = 1'b0;
        mode_i = decompress_defines_pkg::decompress1;
        num_poly_i = 3'd1;
        src_base_addr_i = '0;
        dest_base_addr_i = '0;
        api_rd_data_i = '0;
        for (int a = 0; a < SRC_DEPTH; a++) begin
            src_mem[a] = {$urandom, $urandom};
        end
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        test_mode1_single();
        test_throttled_modes();
        test_mode12_boundaries();
        test_zeroize_abort();

        if (fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("one or more checks did not match");
        end
    end

endmodule

`default_nettype wire

//--- common/abr_params_pkg.sv
// Shared memory and field constants
`default_nettype none

package abr_params_pkg;

    // Memory geometry
    localparam int ABR_MEM_ADDR_WIDTH = 15;
    localparam int DATA_WIDTH = 32;
    localparam int COEFF_PER_CLK = 4;

    // ML-KEM field
    localparam int MLKEM_Q = 3329;
    localparam int MLKEM_Q_WIDTH = 12;
    localparam int MLKEM_N = 256;

    // Memory lane is sized for the wider ML-DSA coefficient
    localparam int MLDSA_Q_WIDTH = 24;

    typedef logic [ABR_MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [MLKEM_Q_WIDTH-1:0] coeff_t;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rd_wr_en_e;

    typedef struct packed {
        rd_wr_en_e rd_wr_en;
        mem_addr_t addr;
    } mem_if_t;

endpackage

`default_nettype wire

//--- common/decompress_defines_pkg.sv
// Decompression modes and widths
`default_nettype none

package decompress_defines_pkg;

    // Encoded as the index into the per-mode rate tables
    typedef enum logic [1:0] {
        decompress1  = 2'd0,
        decompress5  = 2'd1,
        decompress11 = 2'd2,
        decompress12 = 2'd3
    } decompress_mode_t;

    localparam int DECOMP_MAX_D = 12;
    localparam int DECOMP_D_W = $clog2(DECOMP_MAX_D + 1);

    // Bit buffer between the read port and the lanes
    localparam int PISO_IN_W = 64;
    localparam int PISO_OUT_W = 48;
    localparam int PISO_BUF_W = 104;

    // Scaled coefficient before the final shift, 4095 * 3329 + 2048 fits
    localparam int DECOMP_PROD_W = 24;

    typedef logic [DECOMP_PROD_W-1:0] decomp_prod_t;

    function automatic logic [DECOMP_D_W-1:0] decomp_width(input decompress_mode_t mode);
        logic [DECOMP_D_W-1:0] d;
        unique case (mode)
            decompress1:  d = 4'd1;
            decompress5:  d = 4'd5;
            decompress11: d = 4'd11;
            decompress12: d = 4'd12;
            default:      d = 4'd12;
        endcase
        return d;
    endfunction

endpackage

`default_nettype wire

//--- decompress/decompress.sv
// Single coefficient decompression
`default_nettype none

module decompress (
    input  abr_params_pkg::coeff_t op_i,
    input  decompress_defines_pkg::decompress_mode_t mode_i,
    output abr_params_pkg::coeff_t op_o
);

    logic [decompress_defines_pkg::DECOMP_D_W-1:0] d;
    decompress_defines_pkg::decomp_prod_t scaled;
    decompress_defines_pkg::decomp_prod_t rounded;
    decompress_defines_pkg::decomp_prod_t shifted;

    // round(op * q / 2^d), computed as (op * q + 2^(d-1)) >> d
    always_comb begin
        d = decompress_defines_pkg::decomp_width(mode_i);
        scaled = decompress_defines_pkg::decomp_prod_t'(op_i)
               * decompress_defines_pkg::decomp_prod_t'(abr_params_pkg::MLKEM_Q);
        // Half of one output step
        rounded = scaled + (decompress_defines_pkg::decomp_prod_t'(1) << (d - 1'b1));
        shifted = rounded >> d;
        op_o = shifted[abr_params_pkg::MLKEM_Q_WIDTH-1:0];
    end

endmodule

`default_nettype wire

//--- decompress/decompress_ctrl.sv
// Decompression write control
`default_nettype none

module decompress_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  logic decompress_enable_i,
    input  logic [2:0] num_poly_i,
    input  abr_params_pkg::mem_addr_t dest_base_addr_i,
    input  logic mem_wr_valid_i,
    output abr_params_pkg::mem_addr_t mem_wr_addr_o,
    output logic done_o
);

    abr_params_pkg::mem_addr_t wr_addr_q;
    abr_params_pkg::mem_addr_t wr_cnt_q;
    abr_params_pkg::mem_addr_t wr_total;
    logic active_q;
    logic done_q;
    logic last_wr;

    // 64 writes of four coefficients per polynomial
    always_comb begin
        wr_total = abr_params_pkg::mem_addr_t'(num_poly_i)
                 * abr_params_pkg::mem_addr_t'(abr_params_pkg::MLKEM_N
                                               / abr_params_pkg::COEFF_PER_CLK);
        last_wr = mem_wr_valid_i & (wr_cnt_q + 1'b1 == wr_total);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr_q <= '0;
            wr_cnt_q <= '0;
            active_q <= 1'b0;
            done_q <= 1'b0;
        end else if (zeroize_i) begin
            wr_addr_q <= '0;
            wr_cnt_q <= '0;
            active_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= last_wr;
            if (decompress_enable_i) begin
                wr_addr_q <= dest_base_addr_i;
                wr_cnt_q <= '0;
                active_q <= 1'b1;
            end else if (mem_wr_valid_i) begin
                wr_addr_q <= wr_addr_q + 1'b1;
                wr_cnt_q <= wr_cnt_q + 1'b1;
                if (last_wr) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    assign mem_wr_addr_o = wr_addr_q;
    assign done_o = done_q;

    // Buffer must be drained exactly when the count completes
    no_wr_after_done: assert property (
        @(posedge clk) disable iff (!reset_n) mem_wr_valid_i |-> active_q
    ) else $error("write strobe outside an active job");

endmodule

`default_nettype wire

//--- decompress/decompress_top.sv
// Polynomial decompression engine
`default_nettype none

module decompress_top (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,

    input  logic decompress_enable_i,
    input  decompress_defines_pkg::decompress_mode_t mode_i,
    input  logic [2:0] num_poly_i,
    input  abr_params_pkg::mem_addr_t src_base_addr_i,
    input  abr_params_pkg::mem_addr_t dest_base_addr_i,

    output abr_params_pkg::mem_if_t mem_wr_req_o,
    output logic [abr_params_pkg::COEFF_PER_CLK-1:0][abr_params_pkg::MLDSA_Q_WIDTH-1:0]
                 mem_wr_data_o,

    output logic api_rd_en_o,
    output abr_params_pkg::mem_addr_t api_rd_addr_o,
    input  logic [1:0][abr_params_pkg::DATA_WIDTH-1:0] api_rd_data_i,

    output logic decompress_done_o
);

    logic busy_q;
    logic rd_en_q;
    logic read_done;
    logic [decompress_defines_pkg::DECOMP_D_W-1:0] rd_d;
    abr_params_pkg::mem_addr_t rd_end_addr;

    logic piso_hold;
    logic piso_valid;
    logic [decompress_defines_pkg::PISO_OUT_W-1:0] piso_data;

    abr_params_pkg::coeff_t [abr_params_pkg::COEFF_PER_CLK-1:0] coeff_in;
    abr_params_pkg::coeff_t [abr_params_pkg::COEFF_PER_CLK-1:0] coeff_out;

    abr_params_pkg::mem_addr_t wr_addr;
    logic write_done;

    // Busy from the start pulse until the write side reports done
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
        end else if (zeroize_i) begin
            busy_q <= 1'b0;
        end else if (decompress_enable_i) begin
            busy_q <= 1'b1;
        end else if (write_done) begin
            busy_q <= 1'b0;
        end
    end

    assign decompress_done_o = write_done;

    // Read side
    always_comb begin
        rd_d = decompress_defines_pkg::decomp_width(mode_i);
        // Each polynomial takes d * 256 / 64 reads
        rd_end_addr = src_base_addr_i
                    + abr_params_pkg::mem_addr_t'(num_poly_i)
                    * abr_params_pkg::mem_addr_t'(rd_d)
                    * abr_params_pkg::mem_addr_t'(abr_params_pkg::MLKEM_N
                                                  / decompress_defines_pkg::PISO_IN_W);
        read_done = (api_rd_addr_o == rd_end_addr);
        api_rd_en_o = busy_q & ~read_done & ~piso_hold & ~zeroize_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            api_rd_addr_o <= '0;
            rd_en_q <= 1'b0;
        end else if (zeroize_i) begin
            api_rd_addr_o <= '0;
            rd_en_q <= 1'b0;
        end else begin
            // Read data shows up one cycle after the request
            rd_en_q <= api_rd_en_o;
            if (decompress_enable_i) begin
                api_rd_addr_o <= src_base_addr_i;
            end else if (api_rd_en_o) begin
                api_rd_addr_o <= api_rd_addr_o + 1'b1;
            end
        end
    end

    abr_piso_multi #(
        .NUM_MODES(4),
        .BUF_W(decompress_defines_pkg::PISO_BUF_W),
        .IN_W(decompress_defines_pkg::PISO_IN_W),
        .OUT_W(decompress_defines_pkg::PISO_OUT_W),
        // Four coefficients of d bits per output in mode order
        .OUTPUT_RATES('{4, 20, 44, 48})
    ) piso_inst (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .mode_i(mode_i),
        .valid_i(rd_en_q),
        .data_i(api_rd_data_i),
        .hold_o(piso_hold),
        .valid_o(piso_valid),
        .data_o(piso_data)
    );

    // Cut the chunk into d-bit fields with field i at offset i*d
    always_comb begin
        for (int i = 0; i < abr_params_pkg::COEFF_PER_CLK; i++) begin
            unique case (mode_i)
                decompress_defines_pkg::decompress1:
                    coeff_in[i] = abr_params_pkg::coeff_t'(piso_data[i*1 +: 1]);
                decompress_defines_pkg::decompress5:
                    coeff_in[i] = abr_params_pkg::coeff_t'(piso_data[i*5 +: 5]);
                decompress_defines_pkg::decompress11:
                    coeff_in[i] = abr_params_pkg::coeff_t'(piso_data[i*11 +: 11]);
                default:
                    coeff_in[i] = piso_data[i*12 +: 12];
            endcase
        end
    end

    for (genvar i = 0; i < abr_params_pkg::COEFF_PER_CLK; i++) begin : g_lane
        decompress decompress_inst (
            .op_i(coeff_in[i]),
            .mode_i(mode_i),
            .op_o(coeff_out[i])
        );

        // Upper lane bits stay zero
        assign mem_wr_data_o[i] = {
            {(abr_params_pkg::MLDSA_Q_WIDTH - abr_params_pkg::MLKEM_Q_WIDTH){1'b0}},
            coeff_out[i]
        };
    end

    decompress_ctrl ctrl_inst (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .decompress_enable_i(decompress_enable_i),
        .num_poly_i(num_poly_i),
        .dest_base_addr_i(dest_base_addr_i),
        .mem_wr_valid_i(piso_valid),
        .mem_wr_addr_o(wr_addr),
        .done_o(write_done)
    );

    always_comb begin
        mem_wr_req_o.rd_wr_en = piso_valid ? abr_params_pkg::RW_WRITE : abr_params_pkg::RW_IDLE;
        mem_wr_req_o.addr = wr_addr;
    end

    // The write side may only finish once every chunk of the job was read
    reads_complete_at_done: assert property (
        @(posedge clk) disable iff (!reset_n) write_done |-> read_done
    ) else $error("job finished before all source chunks were read");

endmodule

`default_nettype wire

//--- decompress_top.f
+incdir+bench
common/abr_params_pkg.sv
common/decompress_defines_pkg.sv
verilog/abr_piso_multi.sv
decompress/decompress.sv
decompress/decompress_ctrl.sv
decompress/decompress_top.sv
bench/decompress_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decompression engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f decompress_top.f --top-module decompress_top_tb -o decompress_top_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/decompress_top_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
fi
exit "$status"

//--- verilog/abr_piso_multi.sv
// Multi-rate parallel-in serial-out buffer
`default_nettype none

module abr_piso_multi #(
    parameter int NUM_MODES = 4,
    parameter int BUF_W = decompress_defines_pkg::PISO_BUF_W,
    parameter int IN_W = decompress_defines_pkg::PISO_IN_W,
    parameter int OUT_W = decompress_defines_pkg::PISO_OUT_W,
    parameter int OUTPUT_RATES [NUM_MODES] = '{4, 20, 44, 48}
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  logic [$clog2(NUM_MODES)-1:0] mode_i,
    input  logic valid_i,
    input  logic [IN_W-1:0] data_i,
    output logic hold_o,
    output logic valid_o,
    output logic [OUT_W-1:0] data_o
);

    // Room for a full buffer plus one incoming chunk
    localparam int CNT_W = $clog2(BUF_W + IN_W + 1);

    logic [BUF_W-1:0] bit_buf_q;
    logic [BUF_W-1:0] drained;
    logic [BUF_W-1:0] in_shifted;
    logic [CNT_W-1:0] fill_q;
    logic [CNT_W-1:0] fill_after_out;
    logic [CNT_W-1:0] fill_next;
    logic [CNT_W-1:0] rate;

    always_comb begin
        rate = CNT_W'(OUTPUT_RATES[mode_i]);
        valid_o = (fill_q >= rate);

        // Oldest bits sit at the bottom and leave first
        if (valid_o) begin
            fill_after_out = fill_q - rate;
            drained = bit_buf_q >> rate;
        end else begin
            fill_after_out = fill_q;
            drained = bit_buf_q;
        end

        // New chunk lands just above the bits that remain
        in_shifted = BUF_W'(data_i) << fill_after_out;
        fill_next = valid_i ? fill_after_out + CNT_W'(IN_W) : fill_after_out;

        // A read issued now arrives next cycle and must still fit
        hold_o = (fill_next + CNT_W'(IN_W)) > CNT_W'(BUF_W);
    end

    assign data_o = bit_buf_q[OUT_W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_buf_q <= '0;
            fill_q <= '0;
        end else if (zeroize_i) begin
            bit_buf_q <= '0;
            fill_q <= '0;
        end else begin
            bit_buf_q <= valid_i ? (drained | in_shifted) : drained;
            fill_q <= fill_next;
        end
    end

    // Holds only if the requester respects hold_o one cycle ahead
    fill_in_range: assert property (
        @(posedge clk) disable iff (!reset_n) fill_q <= CNT_W'(BUF_W)
    ) else $error("bit buffer overflow");

endmodule

`default_nettype wire
